// ==== bench/tluh_sram_tb.sv ====
`timescale 1ns/1ps

module tluh_sram_tb import tluh_pkg::*; ();

  typedef struct packed {
    logic [2:0]         opcode;
    logic               error;
    logic               chk_data;
    logic [TL_DW-1:0]   data;
    logic [TL_SRCW-1:0] source;
    logic [TL_SZW-1:0]  size;
  } exp_rsp_t;

  logic                clk_i;
  logic                rst_ni;
  logic                a_valid_i;
  logic                a_ready_o;
  logic [2:0]          a_opcode_i;
  logic [2:0]          a_param_i;
  logic [TL_SZW-1:0]   a_size_i;
  logic [TL_SRCW-1:0]  a_source_i;
  logic [TL_AW-1:0]    a_address_i;
  logic [TL_BYTES-1:0] a_mask_i;
  logic [TL_DW-1:0]    a_data_i;
  logic                d_valid_o;
  logic                d_ready_i = 1'b1;
  logic [2:0]          d_opcode_o;
  logic [TL_SZW-1:0]   d_size_o;
  logic [TL_SRCW-1:0]  d_source_o;
  logic                d_error_o;
  logic [TL_DW-1:0]    d_data_o;
  logic                d_fire;

  // reference model state
  logic [TL_DW-1:0]   ref_mem [SRAM_DEPTH];
  exp_rsp_t           exp_q [$];
  exp_rsp_t           exp_head = '0;
  int                 pending = 0;
  logic               second_pending = 1'b0;
  logic [SRAM_AW-1:0] first_word;

  logic [31:0] rng = 32'd5;
  logic [31:0] bp_rng = 32'd5;
  logic        bp_en = 1'b0;
  int          bp_left = 0;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          timeouts = 0;

  tluh_sram_top tluh_sram_top_inst (.*);

  assign d_fire = d_valid_o && d_ready_i;

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] wr,
                                             input logic [3:0] m);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        res[8*b +: 8] = wr[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] arith_ref(input logic [2:0] p, input logic [31:0] old,
                                            input logic [31:0] opnd);
    logic signed [31:0] s_old;
    logic signed [31:0] s_opnd;
    s_old  = old;
    s_opnd = opnd;
    case (p)
      MIN:     return (s_old <= s_opnd) ? old : opnd;
      MAX:     return (s_old >= s_opnd) ? old : opnd;
      MINU:    return (old <= opnd) ? old : opnd;
      MAXU:    return (old >= opnd) ? old : opnd;
      default: return old + opnd;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("ERROR t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
    value_errs++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s at t=%0t", msg, $time);
    proto_errs++;
  endtask

  task automatic push_exp(input logic [2:0] op, input logic err, input logic [31:0] data);
    exp_rsp_t e;
    e.opcode   = op;
    e.error    = err;
    e.chk_data = (op == AccessAckData) && !err;
    e.data     = data;
    e.source   = a_source_i;
    e.size     = a_size_i;
    exp_q.push_back(e);
  endtask

  // model follows every accepted A beat in order
  always @(posedge clk_i) begin
    logic               mis;
    logic               burst;
    logic [SRAM_AW-1:0] w;
    if (rst_ni) begin
      if (d_fire && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (a_valid_i && a_ready_o) begin
        burst = (a_size_i == BURST_SIZE);
        mis   = burst ? (a_address_i[2:0] != 0) : (a_address_i[1:0] != 0);
        w     = second_pending ? first_word + 1 : a_address_i[2 +: SRAM_AW];
        case (a_opcode_i)
          Get: begin
            push_exp(AccessAckData, mis, ref_mem[w]);
            if (burst) begin
              push_exp(AccessAckData, mis, ref_mem[w + 1]);
            end
          end
          PutFullData: begin
            if (!mis) begin
              ref_mem[w] = byte_merge(ref_mem[w], a_data_i, a_mask_i);
            end
            if (!burst || second_pending) begin
              push_exp(AccessAck, mis, '0);
            end
          end
          ArithmeticData: begin
            if (mis || a_param_i > ADD) begin
              push_exp(AccessAckData, 1'b1, '0);
            end else begin
              push_exp(AccessAckData, 1'b0, ref_mem[w]);
              ref_mem[w] = arith_ref(a_param_i, ref_mem[w], a_data_i);
            end
          end
          Intent: push_exp(HintAck, mis, '0);
          default: push_exp(AccessAck, 1'b1, '0);
        endcase
        if (second_pending) begin
          second_pending <= 1'b0;
        end else if (burst && (a_opcode_i == PutFullData || a_opcode_i == ArithmeticData)) begin
          second_pending <= 1'b1;
          first_word     <= w;
        end
      end
    end
    exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
    pending  <= exp_q.size();
  end

  // random stretches of d_ready_i low
  always @(negedge clk_i) begin
    if (!bp_en) begin
      d_ready_i = 1'b1;
    end else if (bp_left == 0) begin
      bp_rng    = xorshift32(bp_rng);
      d_ready_i = bp_rng[0];
      bp_left   = int'(bp_rng[3:1]);
    end else begin
      bp_left--;
    end
  end

  rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni) d_fire |-> pending != 0)
    else note_failure("response on the D channel with none outstanding");
  opcode_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_fire |-> d_opcode_o == exp_head.opcode)
    else report_mismatch("d_opcode_o", $sampled(exp_head.opcode), $sampled(d_opcode_o));
  error_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_fire |-> d_error_o == exp_head.error)
    else report_mismatch("d_error_o", $sampled(exp_head.error), $sampled(d_error_o));
  source_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_fire |-> d_source_o == exp_head.source)
    else report_mismatch("d_source_o", $sampled(exp_head.source), $sampled(d_source_o));
  size_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_fire |-> d_size_o == exp_head.size)
    else report_mismatch("d_size_o", $sampled(exp_head.size), $sampled(d_size_o));
  data_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_fire && exp_head.chk_data |-> d_data_o == exp_head.data)
    else report_mismatch("d_data_o", $sampled(exp_head.data), $sampled(d_data_o));
  d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_opcode_o) && $stable(d_data_o)
      && $stable(d_error_o) && $stable(d_source_o) && $stable(d_size_o))
    else note_failure("D channel changed while stalled");
  a_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending != 0 && !second_pending |-> !a_ready_o)
    else note_failure("a_ready_o high while responses are outstanding");

  task automatic send_beat(input logic [2:0] op, input logic [2:0] param, input logic [1:0] size,
                           input logic [3:0] src, input logic [31:0] addr,
                           input logic [3:0] mask, input logic [31:0] data);
    int n;
    n = 0;
    while (!a_ready_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (!a_ready_o) begin
      $display("timed out waiting for a_ready_o at t=%0t", $time);
      timeouts++;
    end else begin
      a_valid_i   = 1'b1;
      a_opcode_i  = op;
      a_param_i   = param;
      a_size_i    = size;
      a_source_i  = src;
      a_address_i = addr;
      a_mask_i    = mask;
      a_data_i    = data;
      @(negedge clk_i);
      a_valid_i = 1'b0;
    end
  endtask

  task automatic run_txn(input logic [2:0] op, input logic [2:0] param, input logic [1:0] size,
                         input logic [31:0] addr, input logic [3:0] mask,
                         input logic [31:0] d0, input logic [31:0] d1);
    logic [31:0] r;
    r = next_rand();
    send_beat(op, param, size, r[3:0], addr, mask, d0);
    if (size == BURST_SIZE && (op == PutFullData || op == ArithmeticData)) begin
      send_beat(op, param, size, r[3:0], addr, mask, d1);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((pending != 0 || !a_ready_o) && n < 400) begin
      @(negedge clk_i);
      n++;
    end
    if (pending != 0 || !a_ready_o) begin
      $display("timed out waiting for outstanding responses at t=%0t", $time);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [2:0]  op;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_param_i   = '0;
    a_size_i    = 2'd2;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_idle: assert (!d_valid_o && a_ready_o)
      else note_failure("D valid or A ready wrong after reset");

    // known contents for the test window, words 0 to 31
    for (int i = 0; i < 32; i++) begin
      run_txn(PutFullData, 3'd0, 2'd2, i * 4, 4'hF, next_rand(), '0);
    end

    // masked put then get
    addr = (next_rand() % 32) * 4;
    r = next_rand();
    run_txn(PutFullData, 3'd0, 2'd2, addr, r[7:4], next_rand(), '0);
    run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);

    // bursts
    addr = (next_rand() % 16) * 8;
    run_txn(Get, 3'd0, 2'd3, addr, 4'hF, '0, '0);
    addr = (next_rand() % 16) * 8;
    run_txn(PutFullData, 3'd0, 2'd3, addr, 4'hF, next_rand(), next_rand());
    run_txn(Get, 3'd0, 2'd3, addr, 4'hF, '0, '0);

    // operands straddle the signed and unsigned boundaries
    addr = (next_rand() % 32) * 4;
    for (int p = 0; p <= 4; p++) begin
      for (int k = 0; k < 2; k++) begin
        opa = k ? 32'h7FFF_FFFE : 32'hFFFF_FFF0;
        opb = k ? 32'h8000_0003 : 32'h0000_0010;
        run_txn(PutFullData, 3'd0, 2'd2, addr, 4'hF, opa, '0);
        run_txn(ArithmeticData, p[2:0], 2'd2, addr, 4'hF, opb, '0);
        run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);
      end
    end
    addr = (next_rand() % 16) * 8;
    run_txn(ArithmeticData, ADD, 2'd3, addr, 4'hF, next_rand(), next_rand());
    run_txn(Get, 3'd0, 2'd3, addr, 4'hF, '0, '0);

    // intent and error cases, each followed by a get
    addr = (next_rand() % 32) * 4;
    run_txn(Intent, 3'd0, 2'd2, addr, 4'hF, '0, '0);
    run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);
    run_txn(3'd1, 3'd0, 2'd2, addr, 4'hF, 32'hDEAD_BEEF, '0);
    run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);
    run_txn(ArithmeticData, 3'd5, 2'd2, addr, 4'hF, 32'h1, '0);
    run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);
    run_txn(Get, 3'd0, 2'd2, addr + 2, 4'hF, '0, '0);
    run_txn(PutFullData, 3'd0, 2'd2, addr + 1, 4'hF, 32'h1234_5678, '0);
    run_txn(Get, 3'd0, 2'd2, addr, 4'hF, '0, '0);
    wait_idle();

    // random mix under back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    op = Get;
        2'd1:    op = PutFullData;
        2'd2:    op = ArithmeticData;
        default: op = Intent;
      endcase
      addr = r[2] ? {r[9:6], 3'b000} : {r[10:6], 2'b00};
      run_txn(op, 3'(r[13:11] % 5), r[2] ? 2'd3 : 2'd2, addr,
              (op == PutFullData) ? r[17:14] : 4'hF, next_rand(), next_rand());
    end
    wait_idle();
    bp_en = 1'b0;
    repeat (2) @(negedge clk_i);

    $display("checks done: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errs, proto_errs, timeouts);
    if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
logic/tluh_pkg.sv
logic/sram_sp.sv
logic/tluh_req_unpack.sv
logic/tluh_rmw_ctrl.sv
logic/tluh_resp_gen.sv
logic/tluh_sram_top.sv
bench/tluh_sram_tb.sv

// ==== logic/sram_sp.sv ====
`timescale 1ns/1ps

module sram_sp import tluh_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [SRAM_AW-1:0] addr_i,
  input  logic [TL_DW-1:0]   wdata_i,
  input  logic [TL_DW-1:0]   wmask_i,
  output logic [TL_DW-1:0]   rdata_o,
  output logic               rvalid_o
);

  logic [TL_DW-1:0] mem [SRAM_DEPTH];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      // bitwise merge under the mask
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && !we_i;
    end
  end

endmodule

// ==== logic/tluh_pkg.sv ====
package tluh_pkg;

  // tilelink channel widths
  localparam int TL_DW   = 32;
  localparam int TL_AW   = 32;
  localparam int TL_SZW  = 2;
  localparam int TL_SRCW = 4;

  // bytes per data word
  localparam int TL_BYTES = TL_DW / 8;

  // word-addressed backing store
  localparam int SRAM_AW    = 10;
  localparam int SRAM_DEPTH = 1 << SRAM_AW;

  // a_size value for a two-beat burst
  localparam int BURST_SIZE = 3;

  // A channel opcodes served here
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    ArithmeticData = 3'd2,
    Get            = 3'd4,
    Intent         = 3'd5
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    HintAck       = 3'd2
  } tl_d_op_e;

  // arithmetic atomic params
  typedef enum logic [2:0] {
    MIN  = 3'd0,
    MAX  = 3'd1,
    MINU = 3'd2,
    MAXU = 3'd3,
    ADD  = 3'd4
  } tl_arith_e;

  // work item handed from the unpacker to the rmw controller
  typedef enum logic [2:0] {
    BeatRead,
    BeatWrite,
    BeatArith,
    BeatHint,
    BeatErr
  } beat_kind_e;

endpackage

// ==== logic/tluh_req_unpack.sv ====
`timescale 1ns/1ps

module tluh_req_unpack import tluh_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  logic [2:0]          a_opcode_i,
  input  logic [2:0]          a_param_i,
  input  logic [TL_SZW-1:0]   a_size_i,
  input  logic [TL_SRCW-1:0]  a_source_i,
  input  logic [TL_AW-1:0]    a_address_i,
  input  logic [TL_BYTES-1:0] a_mask_i,
  input  logic [TL_DW-1:0]    a_data_i,
  output logic                beat_valid_o,
  input  logic                beat_ready_i,
  output beat_kind_e          beat_kind_o,
  output logic [2:0]          beat_param_o,
  output logic [SRAM_AW-1:0]  beat_addr_o,
  output logic [TL_DW-1:0]    beat_data_o,
  output logic [TL_BYTES-1:0] beat_mask_o,
  output logic                beat_last_o,
  output logic [TL_SRCW-1:0]  txn_source_o,
  output logic [TL_SZW-1:0]   txn_size_o,
  input  logic                txn_done_i
);

  logic               busy_q;
  logic               wait_second_q;
  logic               gen_second_q;
  logic [SRAM_AW-1:0] next_addr_q;
  logic               a_fire;
  logic               first_fire;
  logic               beat_fire;
  logic               is_burst;
  logic               is_get;
  logic               multi_a;
  logic               misaligned;
  logic [SRAM_AW-1:0] word_addr;
  beat_kind_e         dec_kind;
  tl_d_op_e           ack_op;

  // second A beat may only land once the first beat has left the register
  assign a_ready_o  = (!busy_q || wait_second_q) && !beat_valid_o;
  assign a_fire     = a_valid_i && a_ready_o;
  assign first_fire = a_fire && !busy_q;
  assign beat_fire  = beat_valid_o && beat_ready_i;

  assign word_addr  = a_address_i[$clog2(TL_BYTES) +: SRAM_AW];
  assign is_burst   = (a_size_i == BURST_SIZE);
  assign is_get     = (a_opcode_i == Get);
  assign multi_a    = is_burst && (a_opcode_i == PutFullData || a_opcode_i == ArithmeticData);
  assign misaligned = (a_address_i % (is_burst ? 2 * TL_BYTES : TL_BYTES)) != 0;

  always_comb begin
    dec_kind = BeatErr;
    ack_op   = AccessAck;
    case (a_opcode_i)
      Get: begin
        dec_kind = BeatRead;
        ack_op   = AccessAckData;
      end
      PutFullData: begin
        dec_kind = BeatWrite;
        ack_op   = AccessAck;
      end
      ArithmeticData: begin
        dec_kind = (a_param_i > ADD) ? BeatErr : BeatArith;
        ack_op   = AccessAckData;
      end
      Intent: begin
        dec_kind = BeatHint;
        ack_op   = HintAck;
      end
      default: begin
        dec_kind = BeatErr;
      end
    endcase
    if (misaligned) begin
      dec_kind = BeatErr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q        <= 1'b0;
      wait_second_q <= 1'b0;
      gen_second_q  <= 1'b0;
      beat_valid_o  <= 1'b0;
    end else begin
      if (txn_done_i) begin
        busy_q <= 1'b0;
      end else if (first_fire) begin
        busy_q <= 1'b1;
      end
      if (a_fire) begin
        beat_valid_o  <= 1'b1;
        wait_second_q <= first_fire && multi_a;
        gen_second_q  <= first_fire && is_burst && is_get;
      end else if (beat_fire) begin
        // burst get reloads the beat for the next word
        beat_valid_o <= gen_second_q;
        gen_second_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      beat_kind_o  <= dec_kind;
      // error beats carry their ack opcode in the param field
      beat_param_o <= (dec_kind == BeatErr) ? ack_op : a_param_i;
      beat_addr_o  <= wait_second_q ? next_addr_q : word_addr;
      beat_data_o  <= a_data_i;
      beat_mask_o  <= a_mask_i;
      beat_last_o  <= !(first_fire && (multi_a || (is_burst && is_get)));
      next_addr_q  <= word_addr + 1'b1;
    end else if (beat_fire && gen_second_q) begin
      beat_addr_o <= next_addr_q;
      beat_last_o <= 1'b1;
    end
    if (first_fire) begin
      txn_source_o <= a_source_i;
      txn_size_o   <= a_size_i;
    end
  end

  a_size_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_valid_i |-> (a_size_i == 2 || a_size_i == BURST_SIZE));

endmodule

// ==== logic/tluh_resp_gen.sv ====
`timescale 1ns/1ps

module tluh_resp_gen import tluh_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rsp_valid_i,
  output logic               rsp_ready_o,
  input  tl_d_op_e           rsp_opcode_i,
  input  logic [TL_DW-1:0]   rsp_data_i,
  input  logic               rsp_error_i,
  input  logic               rsp_last_i,
  input  logic [TL_SRCW-1:0] txn_source_i,
  input  logic [TL_SZW-1:0]  txn_size_i,
  output logic               d_valid_o,
  input  logic               d_ready_i,
  output logic [2:0]         d_opcode_o,
  output logic [TL_SZW-1:0]  d_size_o,
  output logic [TL_SRCW-1:0] d_source_o,
  output logic               d_error_o,
  output logic [TL_DW-1:0]   d_data_o,
  output logic               txn_done_o
);

  logic last_q;

  // register refills while it drains
  assign rsp_ready_o = !d_valid_o || d_ready_i;

  // source and size held by the unpacker for the whole transaction
  assign d_source_o = txn_source_i;
  assign d_size_o   = txn_size_i;

  assign txn_done_o = d_valid_o && d_ready_i && last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_o <= 1'b0;
    end else if (rsp_valid_i && rsp_ready_o) begin
      d_valid_o <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i && rsp_ready_o) begin
      d_opcode_o <= rsp_opcode_i;
      d_data_o   <= rsp_data_i;
      d_error_o  <= rsp_error_i;
      last_q     <= rsp_last_i;
    end
  end

  d_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_opcode_o) && $stable(d_data_o)
      && $stable(d_error_o) && $stable(d_source_o) && $stable(d_size_o));

endmodule

// ==== logic/tluh_rmw_ctrl.sv ====
`timescale 1ns/1ps

module tluh_rmw_ctrl import tluh_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                beat_valid_i,
  output logic                beat_ready_o,
  input  beat_kind_e          beat_kind_i,
  input  logic [2:0]          beat_param_i,
  input  logic [SRAM_AW-1:0]  beat_addr_i,
  input  logic [TL_DW-1:0]    beat_data_i,
  input  logic [TL_BYTES-1:0] beat_mask_i,
  input  logic                beat_last_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output tl_d_op_e            rsp_opcode_o,
  output logic [TL_DW-1:0]    rsp_data_o,
  output logic                rsp_error_o,
  output logic                rsp_last_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [SRAM_AW-1:0]  mem_addr_o,
  output logic [TL_DW-1:0]    mem_wdata_o,
  output logic [TL_DW-1:0]    mem_wmask_o,
  input  logic [TL_DW-1:0]    mem_rdata_i,
  input  logic                mem_rvalid_i
);

  typedef enum logic [1:0] {
    Idle,
    ReadWait,
    ArithWrite,
    RspHold
  } state_e;

  state_e              state_q;
  beat_kind_e          op_kind_q;
  tl_arith_e           op_param_q;
  logic [SRAM_AW-1:0]  op_addr_q;
  logic [TL_DW-1:0]    op_data_q;
  logic [TL_BYTES-1:0] op_mask_q;
  logic [TL_BYTES-1:0] mask_src;
  logic [TL_DW-1:0]    arith_res;
  logic                take;
  logic                needs_read;
  logic                silent;

  assign beat_ready_o = (state_q == Idle);
  assign take         = beat_valid_i && beat_ready_o;
  assign needs_read   = (beat_kind_i == BeatRead) || (beat_kind_i == BeatArith);

  // first put beat of a burst is acked together with the second
  assign silent = !beat_last_i && ((beat_kind_i == BeatWrite) ||
                  (beat_kind_i == BeatErr && tl_d_op_e'(beat_param_i) == AccessAck));

  // old word sits in rsp_data_o once the read returns
  always_comb begin
    case (op_param_q)
      MIN:     arith_res = ($signed(rsp_data_o) < $signed(op_data_q)) ? rsp_data_o : op_data_q;
      MAX:     arith_res = ($signed(rsp_data_o) > $signed(op_data_q)) ? rsp_data_o : op_data_q;
      MINU:    arith_res = (rsp_data_o < op_data_q) ? rsp_data_o : op_data_q;
      MAXU:    arith_res = (rsp_data_o > op_data_q) ? rsp_data_o : op_data_q;
      default: arith_res = rsp_data_o + op_data_q;
    endcase
  end

  always_comb begin
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = beat_addr_i;
    mem_wdata_o = beat_data_i;
    mask_src    = beat_mask_i;
    if (state_q == ArithWrite) begin
      mem_req_o   = 1'b1;
      mem_we_o    = 1'b1;
      mem_addr_o  = op_addr_q;
      mem_wdata_o = arith_res;
      mask_src    = op_mask_q;
    end else if (take) begin
      mem_req_o = needs_read || (beat_kind_i == BeatWrite);
      mem_we_o  = (beat_kind_i == BeatWrite);
    end
    for (int i = 0; i < TL_BYTES; i++) begin
      mem_wmask_o[8*i +: 8] = {8{mask_src[i]}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      rsp_valid_o <= 1'b0;
    end else begin
      case (state_q)
        Idle: begin
          if (take && needs_read) begin
            state_q <= ReadWait;
          end else if (take && !silent) begin
            rsp_valid_o <= 1'b1;
            state_q     <= RspHold;
          end
        end
        ReadWait: begin
          if (mem_rvalid_i) begin
            rsp_valid_o <= (op_kind_q != BeatArith);
            state_q     <= (op_kind_q == BeatArith) ? ArithWrite : RspHold;
          end
        end
        ArithWrite: begin
          rsp_valid_o <= 1'b1;
          state_q     <= RspHold;
        end
        default: begin
          if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
            state_q     <= Idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      op_kind_q   <= beat_kind_i;
      op_param_q  <= tl_arith_e'(beat_param_i);
      op_addr_q   <= beat_addr_i;
      op_data_q   <= beat_data_i;
      op_mask_q   <= beat_mask_i;
      rsp_last_o  <= beat_last_i;
      rsp_error_o <= (beat_kind_i == BeatErr);
      rsp_data_o  <= '0;
      case (beat_kind_i)
        BeatRead, BeatArith: rsp_opcode_o <= AccessAckData;
        BeatWrite:           rsp_opcode_o <= AccessAck;
        BeatHint:            rsp_opcode_o <= HintAck;
        default:             rsp_opcode_o <= tl_d_op_e'(beat_param_i);
      endcase
    end else if (state_q == ReadWait && mem_rvalid_i) begin
      rsp_data_o <= mem_rdata_i;
    end
  end

  // nothing new goes to the sram while read data is on its way back
  no_req_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_we_o |=> !mem_req_o);

  // a write belongs either to a put beat or to the arith op that read first
  we_only_on_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_we_o |-> mem_req_o && ((state_q == ArithWrite) ? (op_kind_q == BeatArith)
                                : (state_q == Idle && beat_kind_i == BeatWrite)));

endmodule

// ==== logic/tluh_sram_top.sv ====
`timescale 1ns/1ps

module tluh_sram_top import tluh_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  logic [2:0]          a_opcode_i,
  input  logic [2:0]          a_param_i,
  input  logic [TL_SZW-1:0]   a_size_i,
  input  logic [TL_SRCW-1:0]  a_source_i,
  input  logic [TL_AW-1:0]    a_address_i,
  input  logic [TL_BYTES-1:0] a_mask_i,
  input  logic [TL_DW-1:0]    a_data_i,
  output logic                d_valid_o,
  input  logic                d_ready_i,
  output logic [2:0]          d_opcode_o,
  output logic [TL_SZW-1:0]   d_size_o,
  output logic [TL_SRCW-1:0]  d_source_o,
  output logic                d_error_o,
  output logic [TL_DW-1:0]    d_data_o
);

  // unpacker to rmw controller
  logic                beat_valid;
  logic                beat_ready;
  beat_kind_e          beat_kind;
  logic [2:0]          beat_param;
  logic [SRAM_AW-1:0]  beat_addr;
  logic [TL_DW-1:0]    beat_data;
  logic [TL_BYTES-1:0] beat_mask;
  logic                beat_last;
  logic [TL_SRCW-1:0]  txn_source;
  logic [TL_SZW-1:0]   txn_size;
  logic                txn_done;

  // rmw controller to response register
  logic                rsp_valid;
  logic                rsp_ready;
  tl_d_op_e            rsp_opcode;
  logic [TL_DW-1:0]    rsp_data;
  logic                rsp_error;
  logic                rsp_last;

  // sram port
  logic                mem_req;
  logic                mem_we;
  logic [SRAM_AW-1:0]  mem_addr;
  logic [TL_DW-1:0]    mem_wdata;
  logic [TL_DW-1:0]    mem_wmask;
  logic [TL_DW-1:0]    mem_rdata;
  logic                mem_rvalid;

  tluh_req_unpack tluh_req_unpack_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_valid_i    (a_valid_i),
    .a_ready_o    (a_ready_o),
    .a_opcode_i   (a_opcode_i),
    .a_param_i    (a_param_i),
    .a_size_i     (a_size_i),
    .a_source_i   (a_source_i),
    .a_address_i  (a_address_i),
    .a_mask_i     (a_mask_i),
    .a_data_i     (a_data_i),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready),
    .beat_kind_o  (beat_kind),
    .beat_param_o (beat_param),
    .beat_addr_o  (beat_addr),
    .beat_data_o  (beat_data),
    .beat_mask_o  (beat_mask),
    .beat_last_o  (beat_last),
    .txn_source_o (txn_source),
    .txn_size_o   (txn_size),
    .txn_done_i   (txn_done)
  );

  tluh_rmw_ctrl tluh_rmw_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_valid_i (beat_valid),
    .beat_ready_o (beat_ready),
    .beat_kind_i  (beat_kind),
    .beat_param_i (beat_param),
    .beat_addr_i  (beat_addr),
    .beat_data_i  (beat_data),
    .beat_mask_i  (beat_mask),
    .beat_last_i  (beat_last),
    .rsp_valid_o  (rsp_valid),
    .rsp_ready_i  (rsp_ready),
    .rsp_opcode_o (rsp_opcode),
    .rsp_data_o   (rsp_data),
    .rsp_error_o  (rsp_error),
    .rsp_last_o   (rsp_last),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_wmask_o  (mem_wmask),
    .mem_rdata_i  (mem_rdata),
    .mem_rvalid_i (mem_rvalid)
  );

  tluh_resp_gen tluh_resp_gen_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_valid_i  (rsp_valid),
    .rsp_ready_o  (rsp_ready),
    .rsp_opcode_i (rsp_opcode),
    .rsp_data_i   (rsp_data),
    .rsp_error_i  (rsp_error),
    .rsp_last_i   (rsp_last),
    .txn_source_i (txn_source),
    .txn_size_i   (txn_size),
    .d_valid_o    (d_valid_o),
    .d_ready_i    (d_ready_i),
    .d_opcode_o   (d_opcode_o),
    .d_size_o     (d_size_o),
    .d_source_o   (d_source_o),
    .d_error_o    (d_error_o),
    .d_data_o     (d_data_o),
    .txn_done_o   (txn_done)
  );

  sram_sp sram_sp_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .wmask_i  (mem_wmask),
    .rdata_o  (mem_rdata),
    .rvalid_o (mem_rvalid)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tluh_sram_tb -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi
